//--- include/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// data word width
`define ALU_XLEN 32

// shift amount covers one word
`define ALU_SHAMT_W 5

// wide enough to hold a full-word count of 32
`define ALU_CNT_W 6

// extension enables
// an opcode from a disabled extension raises error
`define ALU_EN_ZBA 1
`define ALU_EN_ZBB 1
`define ALU_EN_ZBS 1
`define ALU_EN_ZBP 1

`endif

//--- src/isa_pkg.sv
package isa_pkg;

  // one code per supported instruction
  typedef enum logic [5:0] {
    OP_NONE   = 6'd0,
    OP_ADD    = 6'd1,
    OP_SUB    = 6'd2,
    OP_SH1ADD = 6'd3,
    OP_SH2ADD = 6'd4,
    OP_SH3ADD = 6'd5,
    OP_AND    = 6'd6,
    OP_OR     = 6'd7,
    OP_XOR    = 6'd8,
    OP_ANDN   = 6'd9,
    OP_ORN    = 6'd10,
    OP_XNOR   = 6'd11,
    OP_SLL    = 6'd12,
    OP_SRL    = 6'd13,
    OP_SRA    = 6'd14,
    OP_ROL    = 6'd15,
    OP_ROR    = 6'd16,
    OP_SLT    = 6'd17,
    OP_SLTU   = 6'd18,
    OP_MIN    = 6'd19,
    OP_MAX    = 6'd20,
    OP_MINU   = 6'd21,
    OP_MAXU   = 6'd22,
    OP_CLZ    = 6'd23,
    OP_CTZ    = 6'd24,
    OP_CPOP   = 6'd25,
    OP_SEXT_B = 6'd26,
    OP_SEXT_H = 6'd27,
    OP_PACK   = 6'd28,
    OP_PACKU  = 6'd29,
    OP_PACKH  = 6'd30,
    OP_REV8   = 6'd31,
    OP_ORC_B  = 6'd32,
    OP_BSET   = 6'd33,
    OP_BCLR   = 6'd34,
    OP_BINV   = 6'd35,
    OP_BEXT   = 6'd36,
    // csr write data, register and immediate forms
    OP_CSRW   = 6'd37,
    OP_CSRWI  = 6'd38
  } alu_op_e;

endpackage

//--- src/datapath_pkg.sv
`include "alu_cfg.svh"

package datapath_pkg;

  typedef logic [`ALU_XLEN-1:0]    word_t;
  typedef logic [`ALU_CNT_W-1:0]   count_t;
  typedef logic [`ALU_SHAMT_W-1:0] shamt_t;

  // which unit drives the result register
  typedef enum logic [2:0] {
    SRC_NONE   = 3'd0,
    SRC_ADD    = 3'd1,
    SRC_SHIFT  = 3'd2,
    SRC_COUNT  = 3'd3,
    SRC_FIELD  = 3'd4,
    SRC_CSR_RD = 3'd5,
    SRC_PASS_A = 3'd6,
    SRC_PASS_B = 3'd7
  } res_src_e;

endpackage

//--- src/op_decode.sv
`include "alu_cfg.svh"

module op_decode
  import isa_pkg::*;
  import datapath_pkg::*;
(
  input  alu_op_e   op,
  input  logic      csr_ren,
  output res_src_e  res_src,
  output logic      error
);

  localparam bit zba_on = (`ALU_EN_ZBA != 0);
  localparam bit zbb_on = (`ALU_EN_ZBB != 0);
  localparam bit zbs_on = (`ALU_EN_ZBS != 0);
  localparam bit zbp_on = (`ALU_EN_ZBP != 0);

  logic ext_ok;

  always_comb begin
    res_src = SRC_NONE;
    ext_ok  = 1'b1;
    case (op)
      // csr read only goes through with no other op
      OP_NONE: res_src = csr_ren ? SRC_CSR_RD : SRC_NONE;
      OP_ADD, OP_SUB, OP_SLT, OP_SLTU: res_src = SRC_ADD;
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: begin
        res_src = SRC_ADD;
        ext_ok  = zba_on;
      end
      OP_MIN, OP_MAX, OP_MINU, OP_MAXU: begin
        res_src = SRC_ADD;
        ext_ok  = zbb_on;
      end
      OP_SLL, OP_SRL, OP_SRA: res_src = SRC_SHIFT;
      OP_ROL, OP_ROR: begin
        res_src = SRC_SHIFT;
        ext_ok  = zbb_on;
      end
      OP_BEXT: begin
        res_src = SRC_SHIFT;
        ext_ok  = zbs_on;
      end
      OP_CLZ, OP_CTZ, OP_CPOP: begin
        res_src = SRC_COUNT;
        ext_ok  = zbb_on;
      end
      OP_AND, OP_OR, OP_XOR: res_src = SRC_FIELD;
      OP_ANDN, OP_ORN, OP_XNOR, OP_SEXT_B, OP_SEXT_H, OP_REV8, OP_ORC_B: begin
        res_src = SRC_FIELD;
        ext_ok  = zbb_on;
      end
      // pack and packh live in both zbb and zbp
      OP_PACK, OP_PACKH: begin
        res_src = SRC_FIELD;
        ext_ok  = zbb_on | zbp_on;
      end
      OP_PACKU: begin
        res_src = SRC_FIELD;
        ext_ok  = zbp_on;
      end
      OP_BSET, OP_BCLR, OP_BINV: begin
        res_src = SRC_FIELD;
        ext_ok  = zbs_on;
      end
      OP_CSRW:  res_src = SRC_PASS_B;
      OP_CSRWI: res_src = SRC_PASS_A;
      default:  res_src = SRC_NONE;
    endcase
    if (!ext_ok) begin
      res_src = SRC_NONE;
    end
  end

  assign error = (csr_ren && (op != OP_NONE)) || !ext_ok;

endmodule

//--- src/adder_compare.sv
`include "alu_cfg.svh"

module adder_compare
  import isa_pkg::*;
  import datapath_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   sum
);

  localparam int msb = `ALU_XLEN - 1;

  word_t a_sh;
  word_t b_mod;
  word_t add_out;
  logic  sub_en;
  logic  unsigned_cmp;
  logic  carry_out;
  logic  overflow;
  logic  less;

  // shNadd scales a before the add
  always_comb begin
    case (op)
      OP_SH1ADD: a_sh = a << 1;
      OP_SH2ADD: a_sh = a << 2;
      OP_SH3ADD: a_sh = a << 3;
      default:   a_sh = a;
    endcase
  end

  assign sub_en = op inside {OP_SUB, OP_SLT, OP_SLTU, OP_MIN, OP_MAX, OP_MINU, OP_MAXU};
  assign unsigned_cmp = op inside {OP_SLTU, OP_MINU, OP_MAXU};

  // subtract as a + ~b + 1
  assign b_mod = sub_en ? ~b : b;
  assign {carry_out, add_out} = {1'b0, a_sh} + {1'b0, b_mod} + {{`ALU_XLEN{1'b0}}, sub_en};

  assign overflow = (~a_sh[msb] & ~b_mod[msb] &  add_out[msb]) |
                    ( a_sh[msb] &  b_mod[msb] & ~add_out[msb]);

  // no carry out of a - b means a < b unsigned
  assign less = unsigned_cmp ? ~carry_out : (add_out[msb] ^ overflow);

  always_comb begin
    case (op)
      OP_SLT, OP_SLTU:  sum = {{msb{1'b0}}, less};
      OP_MIN, OP_MINU:  sum = less ? a : b;
      OP_MAX, OP_MAXU:  sum = less ? b : a;
      default:          sum = add_out;
    endcase
  end

endmodule

//--- src/shift_rotate.sv
`include "alu_cfg.svh"

module shift_rotate
  import isa_pkg::*;
  import datapath_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  shamt_t  shamt,
  output word_t   shifted
);

  localparam int w = `ALU_XLEN;

  logic           left;
  shamt_t         amount;
  word_t          mask;
  logic [2*w-2:0] ext;
  logic [2*w-2:0] long_shift;

  assign left = (op == OP_SLL) || (op == OP_ROL);

  // a left move is a right rotate by the negated amount
  assign amount = left ? -shamt : shamt;

  // sll keeps only the bits that moved up
  assign mask = (op == OP_SLL) ? ({w{1'b1}} << shamt) : {w{1'b1}};

  // upper half fills in what comes in from the left
  always_comb begin
    ext[w-1:0] = a;
    case (op)
      OP_SRA:                 ext[2*w-2:w] = {(w-1){a[w-1]}};
      OP_SLL, OP_ROL, OP_ROR: ext[2*w-2:w] = a[w-2:0];
      default:                ext[2*w-2:w] = '0;
    endcase
  end

  assign long_shift = ext >> amount;

  // bext picks bit shamt of a into bit 0
  always_comb begin
    if (op == OP_BEXT) begin
      shifted = {{(w-1){1'b0}}, long_shift[0]};
    end else begin
      shifted = long_shift[w-1:0] & mask;
    end
  end

endmodule

//--- src/bit_count.sv
`include "alu_cfg.svh"

module bit_count
  import isa_pkg::*;
  import datapath_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  output count_t  count
);

  localparam int w = `ALU_XLEN;

  word_t  reversed;
  word_t  lz_in;
  count_t lz;
  count_t ones;

  // ctz is clz of the mirrored word
  always_comb begin
    for (int i = 0; i < w; i++) begin
      reversed[i] = a[w-1-i];
    end
  end

  assign lz_in = (op == OP_CTZ) ? reversed : a;

  // highest set bit wins, an empty word counts the full width
  always_comb begin
    lz = count_t'(w);
    for (int i = 0; i < w; i++) begin
      if (lz_in[i]) begin
        lz = count_t'(w - 1 - i);
      end
    end
  end

  always_comb begin
    ones = '0;
    for (int i = 0; i < w; i++) begin
      ones = ones + count_t'(a[i]);
    end
  end

  assign count = (op == OP_CPOP) ? ones : lz;

endmodule

//--- src/bit_field.sv
`include "alu_cfg.svh"

module bit_field
  import isa_pkg::*;
  import datapath_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   field
);

  word_t one_hot;
  word_t orc;

  // single-bit ops index with the low bits of b
  assign one_hot = word_t'(1) << b[`ALU_SHAMT_W-1:0];

  // every non-zero byte becomes all ones
  always_comb begin
    for (int i = 0; i < `ALU_XLEN / 8; i++) begin
      orc[8*i +: 8] = {8{|a[8*i +: 8]}};
    end
  end

  always_comb begin
    case (op)
      OP_AND:  field = a & b;
      OP_OR:   field = a | b;
      OP_XOR:  field = a ^ b;
      OP_ANDN: field = a & ~b;
      OP_ORN:  field = a | ~b;
      OP_XNOR: field = a ^ ~b;

      OP_SEXT_B: field = {{24{a[7]}}, a[7:0]};
      OP_SEXT_H: field = {{16{a[15]}}, a[15:0]};

      // a lands in the upper half
      OP_PACK:  field = {a[15:0], b[15:0]};
      OP_PACKU: field = {a[31:16], b[31:16]};
      OP_PACKH: field = {16'b0, a[7:0], b[7:0]};

      OP_REV8:  field = {a[7:0], a[15:8], a[23:16], a[31:24]};
      OP_ORC_B: field = orc;

      OP_BSET: field = a | one_hot;
      OP_BCLR: field = a & ~one_hot;
      OP_BINV: field = a ^ one_hot;

      default: field = '0;
    endcase
  end

endmodule

//--- src/result_select.sv
`include "alu_cfg.svh"

module result_select
  import datapath_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     valid_in,
  input  res_src_e res_src,
  input  logic     error_in,
  input  word_t    sum,
  input  word_t    shifted,
  input  count_t   count,
  input  word_t    field,
  input  word_t    csr_rddata,
  input  word_t    a,
  input  word_t    b,
  output word_t    result,
  output logic     error
);

  word_t sel;
  word_t next_result;

  always_comb begin
    case (res_src)
      SRC_ADD:    sel = sum;
      SRC_SHIFT:  sel = shifted;
      SRC_COUNT:  sel = {{(`ALU_XLEN - `ALU_CNT_W){1'b0}}, count};
      SRC_FIELD:  sel = field;
      SRC_CSR_RD: sel = csr_rddata;
      SRC_PASS_A: sel = a;
      SRC_PASS_B: sel = b;
      default:    sel = '0;
    endcase
  end

  // an error always returns zero
  assign next_result = error_in ? '0 : sel;

  // outputs hold while valid_in is low
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      error  <= 1'b0;
    end else if (valid_in) begin
      result <= next_result;
      error  <= error_in;
    end
  end

endmodule

//--- src/alu_top.sv
`include "alu_cfg.svh"

module alu_top
  import isa_pkg::*;
  import datapath_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    valid_in,
  input  alu_op_e op,
  input  logic    csr_ren,
  input  word_t   csr_rddata,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    error
);

  res_src_e res_src;
  logic     dec_error;
  word_t    sum;
  word_t    shifted;
  count_t   count;
  word_t    field;

  op_decode u_op_decode (
    .op      (op),
    .csr_ren (csr_ren),
    .res_src (res_src),
    .error   (dec_error)
  );

  adder_compare u_adder_compare (
    .op  (op),
    .a   (a),
    .b   (b),
    .sum (sum)
  );

  // shift amount comes from the low bits of b
  shift_rotate u_shift_rotate (
    .op      (op),
    .a       (a),
    .shamt   (b[`ALU_SHAMT_W-1:0]),
    .shifted (shifted)
  );

  bit_count u_bit_count (
    .op    (op),
    .a     (a),
    .count (count)
  );

  bit_field u_bit_field (
    .op    (op),
    .a     (a),
    .b     (b),
    .field (field)
  );

  result_select u_result_select (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .res_src    (res_src),
    .error_in   (dec_error),
    .sum        (sum),
    .shifted    (shifted),
    .count      (count),
    .field      (field),
    .csr_rddata (csr_rddata),
    .a          (a),
    .b          (b),
    .result     (result),
    .error      (error)
  );

endmodule

//--- bench/alu_checker.sv
module alu_checker
  import datapath_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  valid_in,
  input word_t result,
  input logic  error
);
  timeunit 1ns;
  timeprecision 1ps;

  // outputs clear in the cycle after reset
  assert property (@(posedge clk) reset |=> (result == '0) && !error)
    else $error("result or error not zero in the cycle after reset");

  // no valid_in means the register keeps its value
  assert property (@(posedge clk) (!reset && !valid_in) |=> $stable(result) && $stable(error))
    else $error("result or error changed while valid_in was low");

  // an error never carries data
  assert property (@(posedge clk) error |-> (result == '0))
    else $error("error is high with a non-zero result");

endmodule

//--- bench/alu_tb.sv
`include "alu_cfg.svh"

module alu_tb
  import isa_pkg::*;
  import datapath_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int xlen = `ALU_XLEN;

  logic    clk;
  logic    reset;
  logic    valid_in;
  alu_op_e op;
  logic    csr_ren;
  word_t   csr_rddata;
  word_t   a;
  word_t   b;
  word_t   result;
  logic    error;

  int value_errors = 0;
  int flag_errors  = 0;
  int other_errors = 0;

  alu_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .op         (op),
    .csr_ren    (csr_ren),
    .csr_rddata (csr_rddata),
    .a          (a),
    .b          (b),
    .result     (result),
    .error      (error)
  );

  bind alu_top alu_checker u_checker (
    .clk(clk), .reset(reset), .valid_in(valid_in), .result(result), .error(error)
  );

  always #50 clk = ~clk;

  function automatic bit ext_enabled(input alu_op_e o);
    case (o)
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: return (`ALU_EN_ZBA != 0);
      OP_CLZ, OP_CTZ, OP_CPOP, OP_SEXT_B, OP_SEXT_H, OP_MIN, OP_MAX, OP_MINU, OP_MAXU,
      OP_ANDN, OP_ORN, OP_XNOR, OP_ROL, OP_ROR, OP_REV8, OP_ORC_B: return (`ALU_EN_ZBB != 0);
      OP_BSET, OP_BCLR, OP_BINV, OP_BEXT: return (`ALU_EN_ZBS != 0);
      OP_PACKU: return (`ALU_EN_ZBP != 0);
      OP_PACK, OP_PACKH: return (`ALU_EN_ZBB != 0) || (`ALU_EN_ZBP != 0);
      default: return 1'b1;
    endcase
  endfunction

  // zeros from the top or the bottom up to the first one
  function automatic word_t zeros_from(input word_t x, input bit from_top);
    int n;
    n = 0;
    for (int i = 0; i < xlen; i++) begin
      if (x[from_top ? xlen - 1 - i : i]) begin
        break;
      end
      n++;
    end
    return word_t'(n);
  endfunction

  // expected result and error for one operation
  function automatic void model_op(input alu_op_e o, input logic ren, input word_t rd,
                                   input word_t x, input word_t y,
                                   output word_t res, output logic err);
    int s;
    s = y[`ALU_SHAMT_W-1:0];
    res = '0;
    case (o)
      OP_NONE:   res = ren ? rd : '0;
      OP_ADD:    res = x + y;
      OP_SUB:    res = x - y;
      OP_SH1ADD: res = (x << 1) + y;
      OP_SH2ADD: res = (x << 2) + y;
      OP_SH3ADD: res = (x << 3) + y;
      OP_AND:    res = x & y;
      OP_OR:     res = x | y;
      OP_XOR:    res = x ^ y;
      OP_ANDN:   res = x & ~y;
      OP_ORN:    res = x | ~y;
      OP_XNOR:   res = ~(x ^ y);
      OP_SLL:    res = x << s;
      OP_SRL:    res = x >> s;
      OP_SRA:    res = $signed(x) >>> s;
      OP_ROL:    res = (x << s) | (x >> ((xlen - s) % xlen));
      OP_ROR:    res = (x >> s) | (x << ((xlen - s) % xlen));
      OP_SLT:    res = word_t'($signed(x) < $signed(y));
      OP_SLTU:   res = word_t'(x < y);
      OP_MIN:    res = ($signed(x) < $signed(y)) ? x : y;
      OP_MAX:    res = ($signed(x) < $signed(y)) ? y : x;
      OP_MINU:   res = (x < y) ? x : y;
      OP_MAXU:   res = (x < y) ? y : x;
      OP_CLZ:    res = zeros_from(x, 1'b1);
      OP_CTZ:    res = zeros_from(x, 1'b0);
      OP_CPOP:   res = word_t'($countones(x));
      OP_SEXT_B: res = word_t'($signed(x[7:0]));
      OP_SEXT_H: res = word_t'($signed(x[15:0]));
      OP_PACK:   res = {x[15:0], y[15:0]};
      OP_PACKU:  res = {x[31:16], y[31:16]};
      OP_PACKH:  res = {16'h0, x[7:0], y[7:0]};
      OP_REV8:   res = {<<8{x}};
      OP_ORC_B: begin
        for (int i = 0; i < xlen / 8; i++) begin
          res[8*i +: 8] = (x[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
      end
      OP_BSET:   res = x | (word_t'(1) << s);
      OP_BCLR:   res = x & ~(word_t'(1) << s);
      OP_BINV:   res = x ^ (word_t'(1) << s);
      OP_BEXT:   res = word_t'(x[s]);
      OP_CSRW:   res = y;
      OP_CSRWI:  res = x;
      default:   res = '0;
    endcase
    err = (ren && (o != OP_NONE)) || !ext_enabled(o);
    if (err) begin
      res = '0;
    end
  endfunction

  task automatic check_word(input string test, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", test, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_error(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b, actual %b", test, exp, act);
      flag_errors++;
    end
  endtask

  // one operation with valid_in for one cycle
  // the result is checked one edge later
  task automatic do_op(input string test, input alu_op_e o, input word_t x, input word_t y,
                       input logic ren, input word_t rd);
    word_t exp_res;
    logic  exp_err;
    string label;
    label = $sformatf("%s %s a=%h b=%h", test, o.name(), x, y);
    @(posedge clk);
    valid_in   <= 1'b1;
    op         <= o;
    a          <= x;
    b          <= y;
    csr_ren    <= ren;
    csr_rddata <= rd;
    @(posedge clk);
    valid_in <= 1'b0;
    @(negedge clk);
    model_op(o, ren, rd, x, y, exp_res, exp_err);
    check_word(label, exp_res, result);
    check_error(label, exp_err, error);
  endtask

  task automatic apply_reset();
    int waited;
    reset    <= 1'b1;
    valid_in <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    waited = 0;
    @(negedge clk);
    while ((result !== '0 || error !== 1'b0) && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (result !== '0 || error !== 1'b0) begin
      $display("reset did not clear result and error within 16 cycles");
      other_errors++;
    end
  endtask

  task automatic arith_ops();
    alu_op_e ops[5] = '{OP_ADD, OP_SUB, OP_SH1ADD, OP_SH2ADD, OP_SH3ADD};
    foreach (ops[k]) begin
      repeat (8) do_op("arith", ops[k], $urandom, $urandom, 1'b0, '0);
    end
  endtask

  task automatic compare_ops();
    alu_op_e ops[6] = '{OP_SLT, OP_SLTU, OP_MIN, OP_MAX, OP_MINU, OP_MAXU};
    word_t edges[5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    foreach (ops[k]) begin
      foreach (edges[i]) begin
        foreach (edges[j]) begin
          do_op("compare", ops[k], edges[i], edges[j], 1'b0, '0);
        end
      end
      repeat (8) do_op("compare", ops[k], $urandom, $urandom, 1'b0, '0);
    end
  endtask

  task automatic shift_ops();
    alu_op_e ops[6] = '{OP_SLL, OP_SRL, OP_SRA, OP_ROL, OP_ROR, OP_BEXT};
    // only the low five bits of b count
    for (int s = 0; s < xlen; s++) begin
      foreach (ops[k]) begin
        do_op("shift", ops[k], $urandom, ($urandom & ~32'h1f) | s, 1'b0, '0);
      end
    end
  endtask

  task automatic count_ops();
    alu_op_e ops[3] = '{OP_CLZ, OP_CTZ, OP_CPOP};
    word_t   words[$];
    words.push_back('0);
    words.push_back('1);
    for (int i = 0; i < xlen; i++) begin
      words.push_back(word_t'(1) << i);
    end
    repeat (8) words.push_back($urandom);
    foreach (ops[k]) begin
      foreach (words[i]) begin
        do_op("count", ops[k], words[i], $urandom, 1'b0, '0);
      end
    end
    do_op("count", OP_CTZ, '0, $urandom, 1'b0, '0);
    check_word("ctz of zero", word_t'(xlen), result);
  endtask

  task automatic field_ops();
    alu_op_e ops[16] = '{OP_AND, OP_OR, OP_XOR, OP_ANDN, OP_ORN, OP_XNOR, OP_SEXT_B,
                         OP_SEXT_H, OP_PACK, OP_PACKU, OP_PACKH, OP_REV8, OP_ORC_B,
                         OP_BSET, OP_BCLR, OP_BINV};
    foreach (ops[k]) begin
      repeat (6) do_op("field", ops[k], $urandom, $urandom, 1'b0, '0);
    end
    do_op("field", OP_ORC_B, 32'h0010_ff00, '0, 1'b0, '0);
  endtask

  task automatic csr_paths();
    repeat (4) do_op("csr read", OP_NONE, $urandom, $urandom, 1'b1, $urandom);
    do_op("no op", OP_NONE, $urandom, $urandom, 1'b0, $urandom);
    repeat (4) do_op("csr write", OP_CSRW, $urandom, $urandom, 1'b0, $urandom);
    repeat (4) do_op("csr write imm", OP_CSRWI, $urandom, $urandom, 1'b0, $urandom);
    // read strobe with any real op is an error
    for (int i = 1; i <= OP_CSRWI; i++) begin
      do_op("csr clash", alu_op_e'(i), $urandom, $urandom, 1'b1, $urandom);
    end
  endtask

  task automatic hold_outputs();
    alu_op_e ops[2] = '{OP_XOR, OP_ADD};
    logic    ren[2] = '{1'b0, 1'b1};
    word_t   x;
    word_t   y;
    word_t   rd;
    word_t   held_res;
    logic    held_err;
    foreach (ops[k]) begin
      x  = $urandom;
      y  = $urandom;
      rd = $urandom;
      do_op("hold", ops[k], x, y, ren[k], rd);
      model_op(ops[k], ren[k], rd, x, y, held_res, held_err);
      repeat (6) begin
        @(posedge clk);
        op         <= alu_op_e'($urandom_range(0, 38));
        a          <= $urandom;
        b          <= $urandom;
        csr_ren    <= $urandom;
        csr_rddata <= $urandom;
        @(negedge clk);
        check_word("hold", held_res, result);
        check_error("hold", held_err, error);
      end
    end
    do_op("before reset", OP_OR, $urandom | 32'h1, '0, 1'b0, '0);
    @(posedge clk);
    apply_reset();
    check_word("after reset", '0, result);
    check_error("after reset", 1'b0, error);
  endtask

  initial begin
    void'($urandom(32'h552bd09f));
    clk        = 1'b0;
    reset      = 1'b1;
    valid_in   = 1'b0;
    op         = OP_NONE;
    csr_ren    = 1'b0;
    csr_rddata = '0;
    a          = '0;
    b          = '0;
    apply_reset();
    arith_ops();
    compare_ops();
    shift_ops();
    count_ops();
    field_ops();
    csr_paths();
    hold_outputs();
    $display("errors: value %0d, flag %0d, other %0d", value_errors, flag_errors, other_errors);
    if (value_errors + flag_errors + other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
src/isa_pkg.sv
src/datapath_pkg.sv
src/op_decode.sv
src/adder_compare.sv
src/shift_rotate.sv
src/bit_count.sv
src/bit_field.sv
src/result_select.sv
src/alu_top.sv
bench/alu_checker.sv
bench/alu_tb.sv
